//--- design/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// ------------------------------
// datapath widths
// ------------------------------
`define XLEN        32
`define REG_ADDR_W  5

// word-addressed memories, both 64 deep
`define IMEM_DEPTH  64
`define DMEM_DEPTH  64

// ------------------------------
// opcode field, instr[31:26]
// ------------------------------
`define OP_RTYPE    6'h00
`define OP_ADDI     6'h08
`define OP_LW       6'h23
`define OP_SW       6'h2b
`define OP_BEQ      6'h04

// ------------------------------
// funct field for R-type, instr[5:0]
// ------------------------------
`define FN_ADD      6'h20
`define FN_SUB      6'h22
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_SLT      6'h2a

`endif

//--- design/cpuPkg.sv
`include "mips_defs.svh"

package cpuPkg;

  // alu function, resolved in decode from opcode and funct
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } aluOp_t;

  // per-instruction control bits, all zero means bubble
  typedef struct packed {
    logic regWrite;
    logic memRead;
    logic memWrite;
    logic aluSrcImm;
    logic regDstRd;
    logic memToReg;
  } ctrl_t;

  // ------------------------------
  // pipeline register payloads
  // ------------------------------
  typedef struct packed {
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] pcPlus4;
  } ifId_t;

  typedef struct packed {
    ctrl_t                  ctrl;
    aluOp_t                 aluOp;
    logic [`XLEN-1:0]       rsVal;
    logic [`XLEN-1:0]       rtVal;
    logic [`XLEN-1:0]       imm;
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    // already resolved between rt and rd
    logic [`REG_ADDR_W-1:0] dest;
  } idEx_t;

  typedef struct packed {
    ctrl_t                  ctrl;
    logic [`XLEN-1:0]       aluResult;
    logic [`XLEN-1:0]       storeData;
    logic [`REG_ADDR_W-1:0] dest;
  } exMem_t;

  typedef struct packed {
    logic                   regWrite;
    logic                   memToReg;
    logic [`XLEN-1:0]       aluResult;
    logic [`XLEN-1:0]       loadData;
    logic [`REG_ADDR_W-1:0] dest;
  } memWb_t;

  // ------------------------------
  // side channels
  // ------------------------------
  // producer as seen by a consumer stage
  typedef struct packed {
    logic                   valid;
    logic [`REG_ADDR_W-1:0] dest;
    logic [`XLEN-1:0]       value;
  } fwdTap_t;

  // one register write, single-cycle strobe
  typedef struct packed {
    logic                   en;
    logic [`REG_ADDR_W-1:0] dest;
    logic [`XLEN-1:0]       data;
  } regWrite_t;

  typedef struct packed {
    logic                            en;
    logic [$clog2(`IMEM_DEPTH)-1:0]  addr;
    logic [`XLEN-1:0]                word;
  } imemLoad_t;

endpackage

//--- design/pipeReg.sv
module pipeReg #(
  parameter type payload_t = logic,
  // leading bits of the payload that carry control
  parameter int  ctrlBits  = 0
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     enable,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  // flush beats the hold, both give an all-zero bubble
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      q <= '0;
    end else if (enable) begin
      q <= d;
    end
  end

  // control bits must stay known once out of reset
  if (ctrlBits > 0) begin : gCtrlCheck
    ctrlKnown: assert property (
      @(posedge clk) disable iff (rst)
      !$isunknown(q[$bits(payload_t)-1 -: ctrlBits])
    ) else $error("pipeReg: unknown control bit on output");
  end

endmodule

//--- design/regFile.sv
`include "mips_defs.svh"

module regFile import cpuPkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`REG_ADDR_W-1:0] rsAddr,
  input  logic [`REG_ADDR_W-1:0] rtAddr,
  input  regWrite_t              wr,
  output logic [`XLEN-1:0]       rsData,
  output logic [`XLEN-1:0]       rtData
);

  localparam int numRegs = 1 << `REG_ADDR_W;

  logic [`XLEN-1:0] regs [numRegs];

  // r0 is never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.en && wr.dest != '0) begin
      regs[wr.dest] <= wr.data;
    end
  end

  // same-cycle write shows up on the read port
  // r0 comes out of storage like any other register
  function automatic logic [`XLEN-1:0] readPort(logic [`REG_ADDR_W-1:0] addr);
    logic [`XLEN-1:0] val;
    if (wr.en && wr.dest == addr) begin
      val = wr.data;
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  always_comb begin
    rsData = readPort(rsAddr);
    rtData = readPort(rtAddr);
  end

  // r0 reads zero through storage and bypass alike
  zeroReg: assert property (
    @(posedge clk) disable iff (rst)
    (rsAddr != '0 || rsData == '0) && (rtAddr != '0 || rtData == '0)
  ) else $error("regFile: r0 read back a nonzero value");

endmodule

//--- design/decodeStage.sv
`include "mips_defs.svh"

module decodeStage import cpuPkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  ifId_t            ifId,
  input  fwdTap_t          exTap,
  input  fwdTap_t          memTap,
  input  fwdTap_t          wbTap,
  input  logic             exIsLoad,
  input  logic             memIsLoad,
  output idEx_t            idEx,
  output logic             stall,
  output logic             idExFlush,
  output logic             branchTaken,
  output logic [`XLEN-1:0] branchTarget
);

  // ------------------------------
  // instruction fields
  // ------------------------------
  logic [5:0]             opcode;
  logic [5:0]             funct;
  logic [`REG_ADDR_W-1:0] rsIdx;
  logic [`REG_ADDR_W-1:0] rtIdx;
  logic [`REG_ADDR_W-1:0] rdIdx;
  logic [`XLEN-1:0]       immExt;

  assign opcode = ifId.instr[31:26];
  assign rsIdx  = ifId.instr[25:21];
  assign rtIdx  = ifId.instr[20:16];
  assign rdIdx  = ifId.instr[15:11];
  assign funct  = ifId.instr[5:0];
  assign immExt = {{(`XLEN-16){ifId.instr[15]}}, ifId.instr[15:0]};

  // ------------------------------
  // control decode
  // ------------------------------
  ctrl_t  ctrl;
  aluOp_t aluOp;
  logic   isBeq;
  logic   usesRs;
  logic   usesRt;

  always_comb begin
    ctrl   = '0;
    aluOp  = ALU_ADD;
    isBeq  = 1'b0;
    usesRs = 1'b1;
    usesRt = 1'b0;
    case (opcode)
      `OP_RTYPE: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDstRd = 1'b1;
        usesRt        = 1'b1;
        case (funct)
          `FN_ADD: aluOp = ALU_ADD;
          `FN_SUB: aluOp = ALU_SUB;
          `FN_AND: aluOp = ALU_AND;
          `FN_OR:  aluOp = ALU_OR;
          `FN_SLT: aluOp = ALU_SLT;
          // unsupported funct, incl. the all-zero word, acts as nop
          default: begin
            ctrl   = '0;
            usesRs = 1'b0;
            usesRt = 1'b0;
          end
        endcase
      end
      `OP_ADDI: begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
      end
      `OP_LW: begin
        ctrl.regWrite  = 1'b1;
        ctrl.memRead   = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.memToReg  = 1'b1;
      end
      `OP_SW: begin
        ctrl.memWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        usesRt         = 1'b1;
      end
      `OP_BEQ: begin
        // no control bits, beq is done once it leaves decode
        isBeq  = 1'b1;
        usesRt = 1'b1;
      end
      default: begin
        usesRs = 1'b0;
      end
    endcase
  end

  // register file, written from the write-back tap
  logic [`XLEN-1:0] rsData;
  logic [`XLEN-1:0] rtData;
  regWrite_t        wbWrite;

  assign wbWrite = '{en: wbTap.valid, dest: wbTap.dest, data: wbTap.value};

  regFile u_regFile (
    .clk   (clk),
    .rst   (rst),
    .rsAddr(rsIdx),
    .rtAddr(rtIdx),
    .wr    (wbWrite),
    .rsData(rsData),
    .rtData(rtData)
  );

  // ------------------------------
  // branch compare
  // ------------------------------
  // MEM/WB is already covered by the read bypass
  logic [`XLEN-1:0] rsCmp;
  logic [`XLEN-1:0] rtCmp;

  assign rsCmp = (memTap.valid && memTap.dest == rsIdx) ? memTap.value : rsData;
  assign rtCmp = (memTap.valid && memTap.dest == rtIdx) ? memTap.value : rtData;

  assign branchTarget = ifId.pcPlus4 + {immExt[`XLEN-3:0], 2'b00};

  // hazards
  logic loadUse;
  logic branchHazard;
  logic memLoadHit;

  assign loadUse = exIsLoad && exTap.valid &&
                   ((usesRs && exTap.dest == rsIdx) || (usesRt && exTap.dest == rtIdx));

  // load in MEM has no valid tap, match on dest alone
  assign memLoadHit = memIsLoad && memTap.dest != '0 &&
                      (memTap.dest == rsIdx || memTap.dest == rtIdx);

  // operand still in EX, or still being loaded
  assign branchHazard = isBeq &&
                        ((exTap.valid && (exTap.dest == rsIdx || exTap.dest == rtIdx)) ||
                         memLoadHit);

  assign stall       = loadUse || branchHazard;
  assign idExFlush   = stall;
  assign branchTaken = isBeq && !branchHazard && (rsCmp == rtCmp);

  // ------------------------------
  // ID/EX payload
  // ------------------------------
  always_comb begin
    idEx.ctrl  = ctrl;
    idEx.aluOp = aluOp;
    idEx.rsVal = rsData;
    idEx.rtVal = rtData;
    idEx.imm   = immExt;
    idEx.rs    = rsIdx;
    idEx.rt    = rtIdx;
    idEx.dest  = ctrl.regDstRd ? rdIdx : rtIdx;
  end

  // a load in EX always trips the beq hazard too
  noBranchOnStall: assert property (
    @(posedge clk) disable iff (rst) !(branchTaken && stall)
  ) else $error("decodeStage: branch taken while stalled");

endmodule

//--- design/executeStage.sv
`include "mips_defs.svh"

module executeStage import cpuPkg::*; (
  input  idEx_t   idEx,
  input  fwdTap_t memTap,
  input  fwdTap_t wbTap,
  output exMem_t  exMem
);

  // ------------------------------
  // operand forwarding
  // ------------------------------
  // newest producer first, so EX/MEM beats MEM/WB
  function automatic logic [`XLEN-1:0] pickOperand(
    logic [`REG_ADDR_W-1:0] src,
    logic [`XLEN-1:0]       regVal
  );
    logic [`XLEN-1:0] val;
    if (memTap.valid && memTap.dest == src) begin
      val = memTap.value;
    end else if (wbTap.valid && wbTap.dest == src) begin
      val = wbTap.value;
    end else begin
      val = regVal;
    end
    return val;
  endfunction

  logic [`XLEN-1:0] opA;
  logic [`XLEN-1:0] opBReg;
  logic [`XLEN-1:0] opB;

  always_comb begin
    opA    = pickOperand(idEx.rs, idEx.rsVal);
    opBReg = pickOperand(idEx.rt, idEx.rtVal);
  end

  // immediate for addi, lw, sw
  assign opB = idEx.ctrl.aluSrcImm ? idEx.imm : opBReg;

  // ------------------------------
  // ALU
  // ------------------------------
  logic [`XLEN-1:0] aluOut;
  logic             lessThan;

  assign lessThan = $signed(opA) < $signed(opB);

  always_comb begin
    case (idEx.aluOp)
      ALU_ADD: aluOut = opA + opB;
      ALU_SUB: aluOut = opA - opB;
      ALU_AND: aluOut = opA & opB;
      ALU_OR:  aluOut = opA | opB;
      ALU_SLT: aluOut = {{(`XLEN-1){1'b0}}, lessThan};
      default: aluOut = '0;
    endcase
  end

  // store data is the forwarded rt, never the immediate
  always_comb begin
    exMem.ctrl      = idEx.ctrl;
    exMem.aluResult = aluOut;
    exMem.storeData = opBReg;
    exMem.dest      = idEx.dest;
  end

endmodule

//--- design/mipsCore.sv
`include "mips_defs.svh"

module mipsCore import cpuPkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  imemLoad_t imemLoad,
  output regWrite_t wb
);

  localparam int imemAw = $clog2(`IMEM_DEPTH);
  localparam int dmemAw = $clog2(`DMEM_DEPTH);

  logic             stall;
  logic             idExFlush;
  logic             branchTaken;
  logic [`XLEN-1:0] branchTarget;

  ifId_t  ifIdD, ifId;
  idEx_t  idExD, idEx;
  exMem_t exMemD, exMem;
  memWb_t memWbD, memWb;

  fwdTap_t exTap, memTap, wbTap;

  // ------------------------------
  // fetch
  // ------------------------------
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] pcPlus4;
  logic [`XLEN-1:0] imem [`IMEM_DEPTH];

  // program load only while held in reset
  always_ff @(posedge clk) begin
    if (rst && imemLoad.en) begin
      imem[imemLoad.addr] <= imemLoad.word;
    end
  end

  assign pcPlus4 = pc + `XLEN'(4);

  // taken branch redirects, stall holds
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (branchTaken) begin
      pc <= branchTarget;
    end else if (!stall) begin
      pc <= pcPlus4;
    end
  end

  assign ifIdD = '{instr: imem[pc[imemAw+1:2]], pcPlus4: pcPlus4};

  // slot after a taken beq is squashed
  pipeReg #(.payload_t(ifId_t), .ctrlBits(6)) ifIdReg (
    .clk(clk), .rst(rst), .enable(!stall), .flush(branchTaken), .d(ifIdD), .q(ifId)
  );

  // ------------------------------
  // decode
  // ------------------------------
  decodeStage u_decodeStage (
    .clk         (clk),
    .rst         (rst),
    .ifId        (ifId),
    .exTap       (exTap),
    .memTap      (memTap),
    .wbTap       (wbTap),
    .exIsLoad    (idEx.ctrl.memRead),
    .memIsLoad   (exMem.ctrl.memRead),
    .idEx        (idExD),
    .stall       (stall),
    .idExFlush   (idExFlush),
    .branchTaken (branchTaken),
    .branchTarget(branchTarget)
  );

  // bubble into EX while decode waits
  pipeReg #(.payload_t(idEx_t), .ctrlBits(9)) idExReg (
    .clk(clk), .rst(rst), .enable(1'b1), .flush(idExFlush), .d(idExD), .q(idEx)
  );

  // ------------------------------
  // execute
  // ------------------------------
  executeStage u_executeStage (
    .idEx  (idEx),
    .memTap(memTap),
    .wbTap (wbTap),
    .exMem (exMemD)
  );

  pipeReg #(.payload_t(exMem_t), .ctrlBits(6)) exMemReg (
    .clk(clk), .rst(rst), .enable(1'b1), .flush(1'b0), .d(exMemD), .q(exMem)
  );

  // ------------------------------
  // memory
  // ------------------------------
  logic [`XLEN-1:0] dmem [`DMEM_DEPTH];
  logic [`XLEN-1:0] loadData;

  // word addressed, low two bits dropped
  assign loadData = dmem[exMem.aluResult[dmemAw+1:2]];

  always_ff @(posedge clk) begin
    if (exMem.ctrl.memWrite) begin
      dmem[exMem.aluResult[dmemAw+1:2]] <= exMem.storeData;
    end
  end

  assign memWbD = '{
    regWrite:  exMem.ctrl.regWrite,
    memToReg:  exMem.ctrl.memToReg,
    aluResult: exMem.aluResult,
    loadData:  loadData,
    dest:      exMem.dest
  };

  pipeReg #(.payload_t(memWb_t), .ctrlBits(2)) memWbReg (
    .clk(clk), .rst(rst), .enable(1'b1), .flush(1'b0), .d(memWbD), .q(memWb)
  );

  // ------------------------------
  // write-back
  // ------------------------------
  // writes to r0 are dropped here, never strobed
  always_comb begin
    wb.en   = memWb.regWrite && memWb.dest != '0;
    wb.dest = memWb.dest;
    wb.data = memWb.memToReg ? memWb.loadData : memWb.aluResult;
  end

  // forwarding taps
  // ex value is the live ALU output, decode only looks at dest
  assign exTap = '{
    valid: idEx.ctrl.regWrite && idEx.dest != '0,
    dest:  idEx.dest,
    value: exMemD.aluResult
  };

  // load data is not ready in MEM, so no forward from a load
  assign memTap = '{
    valid: exMem.ctrl.regWrite && !exMem.ctrl.memRead && exMem.dest != '0,
    dest:  exMem.dest,
    value: exMem.aluResult
  };

  assign wbTap = '{valid: wb.en, dest: wb.dest, value: wb.data};

endmodule

//--- verification/wbChecker.sv
module wbChecker import cpuPkg::*; #(
  parameter int numExp = 1
) (
  input  logic      clk,
  input  regWrite_t wb,
  input  regWrite_t expected [numExp],
  output int        mismatchCount,
  output int        extraCount,
  output int        seenCount
);

  timeunit 1ns;
  timeprecision 1ps;

  int mismatches = 0;
  int extras     = 0;
  int nextIdx    = 0;

  assign mismatchCount = mismatches;
  assign extraCount    = extras;
  assign seenCount     = nextIdx;

  // dest and data must match exactly, x or z counts as a miss
  function automatic logic sameWrite(regWrite_t got, regWrite_t want);
    return (got.dest === want.dest) && (got.data === want.data);
  endfunction

  // ------------------------------
  // write-back monitor
  // ------------------------------
  // wb only moves on the rising edge, so the falling edge sees it settled
  always @(negedge clk) begin
    if ($isunknown(wb.en)) begin
      mismatches++;
      $display("** Error at %0d ns: write-back strobe is unknown", $time);
    end else if (wb.en) begin
      if (nextIdx >= numExp) begin
        // program is parked in its self-loop, nothing more should retire
        extras++;
        $display("unexpected extra register write at %0d ns: r%0d = %h after all %0d writes",
                 $time, wb.dest, wb.data, numExp);
      end else begin
        if (!sameWrite(wb, expected[nextIdx])) begin
          mismatches++;
          $display("** Error at %0d ns: write %0d expected r%0d = %h, got r%0d = %h",
                   $time, nextIdx, expected[nextIdx].dest, expected[nextIdx].data,
                   wb.dest, wb.data);
        end
        // one table slot per strobe, in program order
        nextIdx++;
      end
    end
  end

endmodule

//--- verification/mipsCoreTb.sv
`include "mips_defs.svh"

module mipsCoreTb import cpuPkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int progLen     = 21;
  localparam int numExp      = 15;
  localparam int resetHold   = 4;
  localparam int drainCycles = 20;
  localparam int imemAw      = $clog2(`IMEM_DEPTH);
  // load, reset, four cycles per instruction at worst, plus margin
  localparam int watchdogCycles = progLen + resetHold + progLen * 4 + 40;

  logic      clk;
  logic      rst;
  imemLoad_t imemLoad;
  regWrite_t wb;

  logic [`XLEN-1:0] progTable [progLen];
  regWrite_t        expTable  [numExp];

  int mismatchCount;
  int extraCount;
  int seenCount;

  mipsCore u_mipsCore (.clk(clk), .rst(rst), .imemLoad(imemLoad), .wb(wb));

  wbChecker #(.numExp(numExp)) u_wbChecker (
    .clk(clk), .wb(wb), .expected(expTable),
    .mismatchCount(mismatchCount), .extraCount(extraCount), .seenCount(seenCount)
  );

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------
  // instruction encoders
  // ------------------------------
  // add rd, rs, rt
  function automatic logic [31:0] encodeR(logic [5:0] funct, int rd, int rs, int rt);
    return {`OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
  endfunction

  // fields in bit order, opcode rs rt imm
  function automatic logic [31:0] encodeI(logic [5:0] op, int rs, int rt, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic regWrite_t expWrite(int dest, logic [`XLEN-1:0] data);
    return '{en: 1'b1, dest: 5'(dest), data: data};
  endfunction

  // program and hand-computed write-back sequence
  task automatic fillTables();
    progTable[0]  = encodeI(`OP_ADDI, 0, 1, 5);       // addi r1, r0, 5
    progTable[1]  = encodeI(`OP_ADDI, 0, 2, 14);      // addi r2, r0, 14
    progTable[2]  = encodeR(`FN_ADD, 3, 1, 2);        // add r3, r1, r2
    progTable[3]  = encodeR(`FN_SUB, 4, 3, 1);        // sub r4, r3, r1
    progTable[4]  = encodeR(`FN_AND, 5, 3, 2);        // and r5, r3, r2
    progTable[5]  = encodeR(`FN_OR, 6, 4, 1);         // or r6, r4, r1
    progTable[6]  = encodeR(`FN_SLT, 7, 1, 2);        // slt r7, r1, r2
    progTable[7]  = encodeR(`FN_SLT, 8, 4, 1);        // slt r8, r4, r1
    progTable[8]  = encodeI(`OP_ADDI, 0, 9, -3);      // addi r9, r0, -3
    progTable[9]  = encodeR(`FN_SLT, 10, 9, 1);       // slt r10, r9, r1 (signed)
    progTable[10] = encodeI(`OP_SW, 0, 3, 8);         // sw r3, 8(r0)
    progTable[11] = encodeI(`OP_LW, 0, 11, 8);        // lw r11, 8(r0)
    progTable[12] = encodeR(`FN_ADD, 12, 11, 1);      // add r12, r11, r1, load-use
    progTable[13] = encodeI(`OP_ADDI, 1, 0, 7);       // addi r0, r1, 7, dropped
    progTable[14] = encodeR(`FN_ADD, 13, 0, 1);       // add r13, r0, r1
    progTable[15] = encodeI(`OP_ADDI, 0, 14, 19);     // addi r14, r0, 19
    progTable[16] = encodeI(`OP_BEQ, 14, 3, 1);       // beq r14, r3, +1, taken
    progTable[17] = encodeI(`OP_ADDI, 0, 15, 99);     // skipped
    progTable[18] = encodeI(`OP_BEQ, 1, 2, 1);        // beq r1, r2, +1, not taken
    progTable[19] = encodeI(`OP_ADDI, 0, 16, 33);     // addi r16, r0, 33
    progTable[20] = encodeI(`OP_BEQ, 0, 0, -1);       // park here

    expTable[0]  = expWrite(1, 32'd5);
    expTable[1]  = expWrite(2, 32'd14);
    expTable[2]  = expWrite(3, 32'd19);
    expTable[3]  = expWrite(4, 32'd14);
    expTable[4]  = expWrite(5, 32'd2);
    expTable[5]  = expWrite(6, 32'd15);
    expTable[6]  = expWrite(7, 32'd1);
    expTable[7]  = expWrite(8, 32'd0);
    expTable[8]  = expWrite(9, 32'hffff_fffd);
    expTable[9]  = expWrite(10, 32'd1);
    expTable[10] = expWrite(11, 32'd19);
    expTable[11] = expWrite(12, 32'd24);
    expTable[12] = expWrite(13, 32'd5);
    expTable[13] = expWrite(14, 32'd19);
    expTable[14] = expWrite(16, 32'd33);
  endtask

  // one word per falling edge while rst is high
  task automatic loadProgram();
    for (int i = 0; i < progLen; i++) begin
      @(negedge clk);
      imemLoad = '{en: 1'b1, addr: imemAw'(i), word: progTable[i]};
    end
    @(negedge clk);
    imemLoad = '0;
  endtask

  task automatic printCounts();
    $display("errors: %0d mismatched, %0d unexpected, %0d missing of %0d writes",
             mismatchCount, extraCount, numExp - seenCount, numExp);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    rst      = 1'b1;
    imemLoad = '0;
    fillTables();
    // reset spans the load, then four more cycles
    loadProgram();
    repeat (resetHold) @(negedge clk);
    rst = 1'b0;
    while (seenCount < numExp) @(posedge clk);
    // give a stray write past the table time to show up
    repeat (drainCycles) @(negedge clk);
    @(posedge clk);
    printCounts();
    if (mismatchCount == 0 && extraCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (watchdogCycles) @(posedge clk);
    $display("timeout after %0d cycles, %0d expected register writes never appeared",
             watchdogCycles, numExp - seenCount);
    printCounts();
    $display("Verification failed");
    $finish;
  end

endmodule

//--- sources.f
+incdir+design
design/cpuPkg.sv
design/pipeReg.sv
design/regFile.sv
design/decodeStage.sv
design/executeStage.sv
design/mipsCore.sv
verification/wbChecker.sv
verification/mipsCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
  --top-module mipsCoreTb -o mipsCoreSim \
  || { echo "build failed"; exit 1; }

./obj_dir/mipsCoreSim > sim.log 2>&1 ; cat sim.log

grep -q "Verification failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Verification passed" sim.log || { echo "no verdict found in sim.log"; exit 1; }
exit 0
